//--- rtl/f2_glue_pkg.sv
package f2_glue_pkg;

    localparam int ADDR_W = 23;
    localparam int DATA_W = 16;

    typedef enum logic [2:0] {
        REG_NONE,
        REG_WORK_RAM,
        REG_INPUTS,
        REG_SAVE_HANDLER,
        REG_RESET_VECTOR,
        REG_SAVE_VECTOR
    } region_t;

    // Byte addresses on the 68000 bus
    localparam logic [23:0] WORK_RAM_BASE   = 24'h100000;
    localparam logic [23:0] INPUTS_BASE     = 24'h300000;
    localparam logic [23:0] SS_HANDLER_BASE = 24'hff0000;
    localparam logic [23:0] SS_VECTOR_ADDR  = 24'h00007c;

    // Save handler machine code, fetched from SS_HANDLER_BASE
    localparam logic [15:0] SAVE_HANDLER [13] = '{
        16'h48e7, 16'hfffe, 16'h4e6e, 16'h2f0e,
        16'h4df9, 16'h00ff, 16'h0000, 16'h2c8f,
        16'h2c5f, 16'h4e66, 16'h4cdf, 16'h7fff,
        16'h4e73
    };

    typedef enum logic [3:0] {
        SST_IDLE,
        SST_START_SAVE,
        SST_WAIT_SAVE,
        SST_SAVE_SETTLE,
        SST_SAVE_PAUSED,
        SST_WAIT_HANDLER,
        SST_RESTORE_SETTLE,
        SST_WAIT_RESTORE,
        SST_HOLD_RESET,
        SST_WAIT_RESET
    } ss_state_t;

endpackage

//--- rtl/cpu_bus_if.sv
`timescale 1ns/1ns

interface cpu_bus_if;

    logic [f2_glue_pkg::ADDR_W-1:0] addr;
    logic [1:0]                     ds_n;
    logic                           rw;
    logic                           as_n;
    logic [2:0]                     fc;
    logic [f2_glue_pkg::DATA_W-1:0] dout;

    modport decoder_mp (
        input addr,
        input as_n
    );

    modport sink_mp (
        input addr,
        input ds_n,
        input rw,
        input as_n,
        input fc,
        input dout
    );

endinterface

//--- rtl/address_decoder.sv
`timescale 1ns/1ns

module address_decoder (
    cpu_bus_if.decoder_mp          bus,
    input  logic                   override,
    output f2_glue_pkg::region_t   region
);

    logic [23:0] byte_addr;

    assign byte_addr = {bus.addr, 1'b0};

    always_comb begin
        region = f2_glue_pkg::REG_NONE;
        if (!bus.as_n) begin
            // Save-state windows shadow the normal map
            if (override && byte_addr[23:3] == 21'd0) begin
                region = f2_glue_pkg::REG_RESET_VECTOR;
            end else if (override &&
                         byte_addr[23:2] == f2_glue_pkg::SS_VECTOR_ADDR[23:2]) begin
                region = f2_glue_pkg::REG_SAVE_VECTOR;
            end else if (override &&
                         byte_addr[23:5] == f2_glue_pkg::SS_HANDLER_BASE[23:5]) begin
                region = f2_glue_pkg::REG_SAVE_HANDLER;
            end else if (byte_addr[23:16] == f2_glue_pkg::WORK_RAM_BASE[23:16]) begin
                region = f2_glue_pkg::REG_WORK_RAM;
            end else if (byte_addr[23:3] == f2_glue_pkg::INPUTS_BASE[23:3]) begin
                // Four word registers
                region = f2_glue_pkg::REG_INPUTS;
            end
        end
    end

endmodule

//--- rtl/work_ram.sv
`timescale 1ns/1ns

module work_ram (
    input  logic                           clk,
    cpu_bus_if.sink_mp                     bus,
    input  f2_glue_pkg::region_t           region,
    output logic [f2_glue_pkg::DATA_W-1:0] q
);

    logic [f2_glue_pkg::DATA_W-1:0] mem [0:32767];
    logic                           wr;

    assign wr = (region == f2_glue_pkg::REG_WORK_RAM) && !bus.rw;

    always_ff @(posedge clk) begin
        if (wr && !bus.ds_n[1]) begin
            mem[bus.addr[14:0]][15:8] <= bus.dout[15:8];
        end
        if (wr && !bus.ds_n[0]) begin
            mem[bus.addr[14:0]][7:0] <= bus.dout[7:0];
        end
        q <= mem[bus.addr[14:0]];
    end

endmodule

//--- rtl/cpu_data_path.sv
`timescale 1ns/1ns

module cpu_data_path (
    input  logic                           clk,
    input  logic                           reset,
    cpu_bus_if.sink_mp                     bus,
    input  f2_glue_pkg::region_t           region,
    input  logic [f2_glue_pkg::DATA_W-1:0] ram_q,
    input  logic [7:0]                     joystick_p1,
    input  logic [7:0]                     joystick_p2,
    input  logic [7:0]                     dswa,
    input  logic [7:0]                     dswb,
    input  logic [1:0]                     start,
    input  logic [1:0]                     coin,
    input  logic [f2_glue_pkg::DATA_W-1:0] reset_vector_hi,
    input  logic [f2_glue_pkg::DATA_W-1:0] reset_vector_lo,
    output logic [f2_glue_pkg::DATA_W-1:0] cpu_din,
    output logic                           dtack_n
);

    logic [15:0] inputs_word;
    logic [15:0] handler_word;
    logic        as_prev;

    ////////////////////////////////////////////////////
    // Input ports, active low
    always_comb begin
        case (bus.addr[1:0])
            2'd0: inputs_word = {8'h00, ~dswa};
            2'd1: inputs_word = {8'h00, ~dswb};
            2'd2: inputs_word = {4'h0, ~coin, 2'b00,
                                 ~{start[0], joystick_p1[6:4], joystick_p1[0],
                                   joystick_p1[1], joystick_p1[2], joystick_p1[3]}};
            default: inputs_word = {8'h00,
                                    ~{start[1], joystick_p2[6:4], joystick_p2[0],
                                      joystick_p2[1], joystick_p2[2], joystick_p2[3]}};
        endcase
    end

    // Table is 13 words in a 16-word window
    assign handler_word = (bus.addr[3:0] < 4'd13) ?
                          f2_glue_pkg::SAVE_HANDLER[bus.addr[3:0]] : 16'h0000;

    ////////////////////////////////////////////////////
    // Read mux
    always_comb begin
        case (region)
            f2_glue_pkg::REG_SAVE_HANDLER: cpu_din = handler_word;
            f2_glue_pkg::REG_RESET_VECTOR: begin
                case (bus.addr[1:0])
                    2'd0: cpu_din = reset_vector_hi;
                    2'd1: cpu_din = reset_vector_lo;
                    2'd2: cpu_din = 16'h00ff;
                    default: cpu_din = 16'h0008;
                endcase
            end
            f2_glue_pkg::REG_SAVE_VECTOR: cpu_din = bus.addr[0] ? 16'h0000 : 16'h00ff;
            f2_glue_pkg::REG_WORK_RAM: cpu_din = ram_q;
            f2_glue_pkg::REG_INPUTS: cpu_din = inputs_word;
            default: cpu_din = 16'h0000;
        endcase
    end

    // Ack only a cycle that is mapped when AS first falls
    always_ff @(posedge clk) begin
        if (reset) begin
            as_prev <= 1'b1;
            dtack_n <= 1'b1;
        end else begin
            as_prev <= bus.as_n;
            if (bus.as_n) begin
                dtack_n <= 1'b1;
            end else if (as_prev && region != f2_glue_pkg::REG_NONE) begin
                dtack_n <= 1'b0;
            end
        end
    end

endmodule

//--- rtl/interrupt_ctrl.sv
`timescale 1ns/1ns

module interrupt_ctrl (
    input  logic        clk,
    input  logic        reset,
    cpu_bus_if.sink_mp  bus,
    input  logic        vblank_n,
    input  logic        dma_n,
    input  logic        ss_do_save,
    output logic [2:0]  ipl_n
);

    // Bit 0 is level 5, bit 1 level 6, bit 2 level 7
    logic [2:0] src;
    logic [2:0] src_prev;
    logic [2:0] req;
    logic [2:0] req_next;
    logic [2:0] ack;
    logic [2:0] level_next;

    assign src = {ss_do_save, dma_n, ~vblank_n};

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            ack[i] = (bus.fc == 3'b111) && !bus.as_n && !bus.ds_n[0] &&
                     (bus.addr[2:0] == 3'(i + 5));
        end
        // Acknowledge wins over a new edge
        req_next = (req | (src & ~src_prev)) & ~ack;
        if (req_next[2]) begin
            level_next = 3'd7;
        end else if (req_next[1]) begin
            level_next = 3'd6;
        end else if (req_next[0]) begin
            level_next = 3'd5;
        end else begin
            level_next = 3'd0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            src_prev <= 3'b010;
            req      <= 3'b000;
            ipl_n    <= 3'b111;
        end else begin
            src_prev <= src;
            req      <= req_next;
            ipl_n    <= ~level_next;
        end
    end

endmodule

//--- rtl/save_state_seq.sv
`timescale 1ns/1ns

module save_state_seq #(
    parameter int SETTLE_CYCLES = 64,
    parameter int HOLD_CYCLES   = 1000
) (
    input  logic                           clk,
    input  logic                           reset,
    cpu_bus_if.sink_mp                     bus,
    input  f2_glue_pkg::region_t           region,
    input  logic                           ss_do_save,
    input  logic                           ss_do_restore,
    input  logic                           ss_busy,
    input  logic [31:0]                    ss_restore_ssp,
    output logic [31:0]                    ss_saved_ssp,
    output logic                           ss_write,
    output logic                           ss_read,
    output logic                           pause,
    output logic                           cpu_reset,
    output logic                           override,
    output logic [f2_glue_pkg::DATA_W-1:0] reset_vector_hi,
    output logic [f2_glue_pkg::DATA_W-1:0] reset_vector_lo,
    output f2_glue_pkg::ss_state_t         ss_state
);

    f2_glue_pkg::ss_state_t state_next;
    logic [15:0]            counter;
    logic [23:0]            byte_addr;
    logic                   sup_word_wr;
    logic                   handler_fetch;

    assign byte_addr   = {bus.addr, 1'b0};
    assign sup_word_wr = !bus.as_n && bus.ds_n == 2'b00 && !bus.rw && bus.fc[2];
    assign handler_fetch = region == f2_glue_pkg::REG_SAVE_HANDLER && bus.rw &&
                           bus.fc == 3'b110 && bus.ds_n == 2'b00;

    always_comb begin
        state_next = ss_state;
        case (ss_state)
            f2_glue_pkg::SST_IDLE: begin
                if (ss_do_restore) begin
                    state_next = f2_glue_pkg::SST_RESTORE_SETTLE;
                end else if (ss_do_save) begin
                    state_next = f2_glue_pkg::SST_START_SAVE;
                end
            end
            // Handler pushes the stack pointer, high word first
            f2_glue_pkg::SST_START_SAVE: begin
                if (sup_word_wr && byte_addr == f2_glue_pkg::SS_HANDLER_BASE) begin
                    state_next = f2_glue_pkg::SST_WAIT_SAVE;
                end
            end
            f2_glue_pkg::SST_WAIT_SAVE: begin
                if (sup_word_wr && byte_addr == f2_glue_pkg::SS_HANDLER_BASE + 24'd2) begin
                    state_next = f2_glue_pkg::SST_SAVE_SETTLE;
                end
            end
            f2_glue_pkg::SST_SAVE_SETTLE: begin
                if (counter == 16'(SETTLE_CYCLES)) begin
                    state_next = f2_glue_pkg::SST_SAVE_PAUSED;
                end
            end
            f2_glue_pkg::SST_SAVE_PAUSED: begin
                if (!ss_busy && !ss_write) begin
                    state_next = f2_glue_pkg::SST_WAIT_HANDLER;
                end
            end
            f2_glue_pkg::SST_RESTORE_SETTLE: begin
                if (counter == 16'(SETTLE_CYCLES)) begin
                    state_next = f2_glue_pkg::SST_WAIT_RESTORE;
                end
            end
            f2_glue_pkg::SST_WAIT_RESTORE: begin
                if (!ss_busy && !ss_read) begin
                    state_next = f2_glue_pkg::SST_HOLD_RESET;
                end
            end
            f2_glue_pkg::SST_HOLD_RESET: begin
                if (counter == 16'(HOLD_CYCLES)) begin
                    state_next = f2_glue_pkg::SST_WAIT_RESET;
                end
            end
            f2_glue_pkg::SST_WAIT_HANDLER, f2_glue_pkg::SST_WAIT_RESET: begin
                if (handler_fetch) begin
                    state_next = f2_glue_pkg::SST_IDLE;
                end
            end
            default: state_next = f2_glue_pkg::SST_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////
    // State, strobes and decoded outputs
    always_ff @(posedge clk) begin
        if (reset) begin
            ss_state  <= f2_glue_pkg::SST_IDLE;
            counter   <= 16'd0;
            ss_write  <= 1'b0;
            ss_read   <= 1'b0;
            pause     <= 1'b0;
            cpu_reset <= 1'b1;
            override  <= 1'b0;
        end else begin
            ss_state <= state_next;
            counter  <= (state_next != ss_state) ? 16'd0 : counter + 16'd1;
            if (ss_state == f2_glue_pkg::SST_SAVE_SETTLE &&
                state_next == f2_glue_pkg::SST_SAVE_PAUSED) begin
                ss_write <= 1'b1;
            end else if (ss_busy) begin
                ss_write <= 1'b0;
            end
            if (ss_state == f2_glue_pkg::SST_RESTORE_SETTLE &&
                state_next == f2_glue_pkg::SST_WAIT_RESTORE) begin
                ss_read <= 1'b1;
            end else if (ss_busy) begin
                ss_read <= 1'b0;
            end
            pause <= state_next inside {f2_glue_pkg::SST_SAVE_SETTLE,
                                        f2_glue_pkg::SST_SAVE_PAUSED,
                                        f2_glue_pkg::SST_WAIT_RESTORE};
            // CPU stays in reset until the new vector is in place
            cpu_reset <= state_next inside {f2_glue_pkg::SST_RESTORE_SETTLE,
                                            f2_glue_pkg::SST_WAIT_RESTORE,
                                            f2_glue_pkg::SST_HOLD_RESET};
            override <= state_next != f2_glue_pkg::SST_IDLE;
        end
    end

    always_ff @(posedge clk) begin
        if (ss_state == f2_glue_pkg::SST_START_SAVE &&
            state_next == f2_glue_pkg::SST_WAIT_SAVE) begin
            ss_saved_ssp[31:16] <= bus.dout;
        end
        if (ss_state == f2_glue_pkg::SST_WAIT_SAVE &&
            state_next == f2_glue_pkg::SST_SAVE_SETTLE) begin
            ss_saved_ssp[15:0] <= bus.dout;
        end
        if (ss_state == f2_glue_pkg::SST_WAIT_RESTORE &&
            state_next == f2_glue_pkg::SST_HOLD_RESET) begin
            reset_vector_hi <= ss_restore_ssp[31:16];
            reset_vector_lo <= ss_restore_ssp[15:0];
        end
    end

endmodule

//--- rtl/f2_cpu_glue.sv
`timescale 1ns/1ns

module f2_cpu_glue #(
    parameter int SETTLE_CYCLES = 64,
    parameter int HOLD_CYCLES   = 1000
) (
    input  logic        clk,
    input  logic        reset,

    input  logic [22:0] cpu_addr,
    input  logic [1:0]  cpu_ds_n,
    input  logic        cpu_rw,
    input  logic        cpu_as_n,
    input  logic [2:0]  cpu_fc,
    input  logic [15:0] cpu_dout,
    output logic [15:0] cpu_din,
    output logic        dtack_n,
    output logic [2:0]  ipl_n,
    output logic        cpu_reset,
    output logic        pause,

    input  logic [7:0]  joystick_p1,
    input  logic [7:0]  joystick_p2,
    input  logic [7:0]  dswa,
    input  logic [7:0]  dswb,
    input  logic [1:0]  start,
    input  logic [1:0]  coin,

    input  logic        vblank_n,
    input  logic        dma_n,

    input  logic        ss_do_save,
    input  logic        ss_do_restore,
    input  logic        ss_busy,
    input  logic [31:0] ss_restore_ssp,
    output logic [31:0] ss_saved_ssp,
    output logic        ss_write,
    output logic        ss_read,
    output logic [3:0]  ss_state
);

    f2_glue_pkg::region_t   region;
    f2_glue_pkg::ss_state_t seq_state;
    logic                   override;
    logic [15:0]            ram_q;
    logic [15:0]            reset_vector_hi;
    logic [15:0]            reset_vector_lo;

    cpu_bus_if bus ();

    assign bus.addr = cpu_addr;
    assign bus.ds_n = cpu_ds_n;
    assign bus.rw   = cpu_rw;
    assign bus.as_n = cpu_as_n;
    assign bus.fc   = cpu_fc;
    assign bus.dout = cpu_dout;
    assign ss_state = seq_state;

    address_decoder u_decoder (.bus(bus.decoder_mp), .override, .region);

    work_ram u_work_ram (.clk, .bus(bus.sink_mp), .region, .q(ram_q));

    cpu_data_path u_data_path (
        .clk, .reset, .bus(bus.sink_mp), .region, .ram_q,
        .joystick_p1, .joystick_p2, .dswa, .dswb, .start, .coin,
        .reset_vector_hi, .reset_vector_lo, .cpu_din, .dtack_n
    );

    interrupt_ctrl u_interrupts (
        .clk, .reset, .bus(bus.sink_mp), .vblank_n, .dma_n, .ss_do_save, .ipl_n
    );

    save_state_seq #(
        .SETTLE_CYCLES(SETTLE_CYCLES),
        .HOLD_CYCLES(HOLD_CYCLES)
    ) u_save_seq (
        .clk, .reset, .bus(bus.sink_mp), .region,
        .ss_do_save, .ss_do_restore, .ss_busy, .ss_restore_ssp, .ss_saved_ssp,
        .ss_write, .ss_read, .pause, .cpu_reset, .override,
        .reset_vector_hi, .reset_vector_lo, .ss_state(seq_state)
    );

endmodule

//--- testbench/f2_cpu_glue_sva.sv
`timescale 1ns/1ns

module f2_cpu_glue_sva (
    input logic       clk,
    input logic       reset,
    input logic       cpu_as_n,
    input logic       dtack_n,
    input logic [2:0] ipl_n,
    input logic [2:0] req,
    input logic       ss_write,
    input logic       ss_read,
    input logic       cpu_reset,
    input logic [3:0] ss_state
);

    logic [2:0] pending_level;

    // Highest pending request
    always_comb begin
        if (req[2]) begin
            pending_level = 3'd7;
        end else if (req[1]) begin
            pending_level = 3'd6;
        end else if (req[0]) begin
            pending_level = 3'd5;
        end else begin
            pending_level = 3'd0;
        end
    end

    ipl_covers_pending: assert property (@(posedge clk) disable iff (reset)
        3'(~ipl_n) >= pending_level)
        else $error("IPL shows a level below a pending request");

    dtack_idle: assert property (@(posedge clk) disable iff (reset)
        cpu_as_n |=> dtack_n)
        else $error("DTACK low while AS is high");

    strobes_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(ss_write && ss_read))
        else $error("ss_write and ss_read high together");

    reset_in_hold: assert property (@(posedge clk) disable iff (reset)
        ss_state == 4'(f2_glue_pkg::SST_HOLD_RESET) |-> cpu_reset)
        else $error("cpu_reset low in the hold state");

endmodule

bind f2_cpu_glue f2_cpu_glue_sva u_sva (
    .clk,
    .reset,
    .cpu_as_n,
    .dtack_n,
    .ipl_n,
    .req(u_interrupts.req),
    .ss_write,
    .ss_read,
    .cpu_reset,
    .ss_state
);

//--- testbench/tb_f2_cpu_glue.sv
`timescale 1ns/1ns

module tb_f2_cpu_glue;

    localparam int SETTLE      = 8;
    localparam int HOLD        = 20;
    localparam int DTACK_LIMIT = 16;

    // Rough test lengths in clock cycles
    localparam int RAM_CYCLES      = 600;
    localparam int INPUT_CYCLES    = 100;
    localparam int IRQ_CYCLES      = 40;
    localparam int SAVE_CYCLES     = 150;
    localparam int RESTORE_CYCLES  = 120;
    localparam int WATCHDOG_CYCLES = 20 * (RAM_CYCLES + INPUT_CYCLES + IRQ_CYCLES +
                                           SAVE_CYCLES + RESTORE_CYCLES);

    // Conditions for wait_until
    localparam int W_PAUSE     = 0;
    localparam int W_WRITE     = 1;
    localparam int W_READ      = 2;
    localparam int W_RESET_ON  = 3;
    localparam int W_RESET_OFF = 4;
    localparam int W_HANDLER   = 5;

    logic        clk;
    logic        reset;
    logic [22:0] cpu_addr;
    logic [1:0]  cpu_ds_n;
    logic        cpu_rw;
    logic        cpu_as_n;
    logic [2:0]  cpu_fc;
    logic [15:0] cpu_dout;
    logic [15:0] cpu_din;
    logic        dtack_n;
    logic [2:0]  ipl_n;
    logic        cpu_reset;
    logic        pause;
    logic [7:0]  joystick_p1;
    logic [7:0]  joystick_p2;
    logic [7:0]  dswa;
    logic [7:0]  dswb;
    logic [1:0]  start;
    logic [1:0]  coin;
    logic        vblank_n;
    logic        dma_n;
    logic        ss_do_save;
    logic        ss_do_restore;
    logic        ss_busy;
    logic [31:0] ss_restore_ssp;
    logic [31:0] ss_saved_ssp;
    logic        ss_write;
    logic        ss_read;
    logic [3:0]  ss_state;

    logic [15:0] shadow_ram [0:32767];
    integer      seed = 32'hdb69_a26b;
    int          errors = 0;
    string       cmp_name;
    logic [15:0] cmp_exp;
    logic [15:0] cmp_act;
    event        read_done;

    f2_cpu_glue #(
        .SETTLE_CYCLES(SETTLE),
        .HOLD_CYCLES(HOLD)
    ) dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    ////////////////////////////////////////////////////
    // Reference model and checks

    function automatic logic [15:0] expected_word(input logic [23:0] byte_addr);
        logic [15:0] w;
        logic [7:0]  joy;
        logic        st;
        int          idx;
        w = 16'h0000;
        if (byte_addr < 24'h000008) begin
            case (byte_addr[2:1])
                2'd0: w = ss_restore_ssp[31:16];
                2'd1: w = ss_restore_ssp[15:0];
                2'd2: w = 16'h00ff;
                default: w = 16'h0008;
            endcase
        end else if (byte_addr == 24'h00007c) begin
            w = 16'h00ff;
        end else if (byte_addr[23:16] == 8'h10) begin
            w = shadow_ram[byte_addr[15:1]];
        end else if (byte_addr >= 24'hff0000 && byte_addr < 24'hff0020) begin
            idx = int'(byte_addr[4:1]);
            if (idx < 13) begin
                w = f2_glue_pkg::SAVE_HANDLER[idx];
            end
        end else if (byte_addr >= 24'h300000 && byte_addr < 24'h300008) begin
            if (byte_addr[2:1] == 2'd0) begin
                w[7:0] = ~dswa;
            end else if (byte_addr[2:1] == 2'd1) begin
                w[7:0] = ~dswb;
            end else begin
                joy = byte_addr[1] && byte_addr[2] ? joystick_p2 : joystick_p1;
                st  = byte_addr[1] && byte_addr[2] ? start[1] : start[0];
                // Directions come in reversed bit order
                w[7]   = ~st;
                w[6:4] = ~joy[6:4];
                w[3]   = ~joy[0];
                w[2]   = ~joy[1];
                w[1]   = ~joy[2];
                w[0]   = ~joy[3];
                if (byte_addr[2:1] == 2'd2) begin
                    w[11:10] = ~coin;
                end
            end
        end
        return w;
    endfunction

    // IPL lines carry the inverted interrupt level
    function automatic logic [2:0] ipl_for_level(input int level);
        logic [2:0] code;
        code = 3'(level);
        return ~code;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    always @(read_done) begin
        check_value(cmp_name, 32'(cmp_exp), 32'(cmp_act));
    end

    function automatic logic [23:0] slot_addr(input int i);
        return 24'h100000 + 24'(i * 2042);
    endfunction

    function automatic logic condition(input int sel);
        case (sel)
            W_PAUSE:     return pause;
            W_WRITE:     return ss_write;
            W_READ:      return ss_read;
            W_RESET_ON:  return cpu_reset;
            W_RESET_OFF: return !cpu_reset;
            W_HANDLER:   return ss_state == 4'(f2_glue_pkg::SST_WAIT_HANDLER);
            default:     return 1'b0;
        endcase
    endfunction

    task automatic wait_until(input int sel, input string what, input int limit);
        int n;
        n = 0;
        while (!condition(sel) && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (!condition(sel)) begin
            errors++;
            $display("Timed out after %0d cycles waiting for %s", limit, what);
        end
    endtask

    ////////////////////////////////////////////////////
    // CPU bus cycles

    task automatic bus_read(input logic [23:0] byte_addr, input logic [2:0] fc,
                            output logic [15:0] data);
        int waited;
        @(negedge clk);
        cpu_addr = byte_addr[23:1];
        cpu_ds_n = 2'b00;
        cpu_rw   = 1'b1;
        cpu_fc   = fc;
        cpu_as_n = 1'b0;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (dtack_n && waited < DTACK_LIMIT);
        if (dtack_n) begin
            errors++;
            $display("DTACK never came for the read at %h", byte_addr);
        end
        data     = cpu_din;
        cpu_as_n = 1'b1;
        cpu_ds_n = 2'b11;
    endtask

    task automatic bus_write(input logic [23:0] byte_addr, input logic [2:0] fc,
                             input logic [1:0] ds_n, input logic [15:0] data);
        int waited;
        @(negedge clk);
        cpu_addr = byte_addr[23:1];
        cpu_ds_n = ds_n;
        cpu_rw   = 1'b0;
        cpu_fc   = fc;
        cpu_dout = data;
        cpu_as_n = 1'b0;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (dtack_n && waited < DTACK_LIMIT);
        if (dtack_n) begin
            errors++;
            $display("DTACK never came for the write at %h", byte_addr);
        end
        cpu_as_n = 1'b1;
        cpu_ds_n = 2'b11;
        cpu_rw   = 1'b1;
    endtask

    task automatic ram_write(input logic [23:0] byte_addr, input logic [1:0] ds_n,
                             input logic [15:0] data);
        bus_write(byte_addr, 3'b101, ds_n, data);
        if (!ds_n[1]) begin
            shadow_ram[byte_addr[15:1]][15:8] = data[15:8];
        end
        if (!ds_n[0]) begin
            shadow_ram[byte_addr[15:1]][7:0] = data[7:0];
        end
    endtask

    task automatic read_check(input string name, input logic [23:0] byte_addr);
        logic [15:0] data;
        bus_read(byte_addr, 3'b101, data);
        cmp_name = name;
        cmp_exp  = expected_word(byte_addr);
        cmp_act  = data;
        -> read_done;
    endtask

    // Autovectored interrupt acknowledge without DTACK
    task automatic int_ack(input logic [2:0] level);
        @(negedge clk);
        cpu_addr = {20'hfffff, level};
        cpu_fc   = 3'b111;
        cpu_rw   = 1'b1;
        cpu_ds_n = 2'b10;
        cpu_as_n = 1'b0;
        @(negedge clk);
        cpu_as_n = 1'b1;
        cpu_ds_n = 2'b11;
        cpu_fc   = 3'b000;
    endtask

    ////////////////////////////////////////////////////
    // Test sequence

    initial begin
        logic [23:0] addr;
        logic [15:0] wdata;
        logic [15:0] data;
        logic [1:0]  lanes;
        logic [31:0] ssp_value;
        reset = 1'b1;
        cpu_addr = '0;
        cpu_ds_n = 2'b11;
        cpu_rw = 1'b1;
        cpu_as_n = 1'b1;
        cpu_fc = 3'b000;
        cpu_dout = '0;
        joystick_p1 = '0;
        joystick_p2 = '0;
        dswa = '0;
        dswb = '0;
        start = '0;
        coin = '0;
        vblank_n = 1'b1;
        dma_n = 1'b1;
        ss_do_save = 1'b0;
        ss_do_restore = 1'b0;
        ss_busy = 1'b0;
        ss_restore_ssp = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Work RAM gets full words first and then mixed lanes
        for (int i = 0; i < 32; i++) begin
            ram_write(slot_addr(i), 2'b00, 16'($random(seed)));
        end
        for (int i = 0; i < 40; i++) begin
            addr  = slot_addr(int'($unsigned($random(seed)) % 32));
            lanes = 2'($unsigned($random(seed)) % 3);
            wdata = 16'($random(seed));
            ram_write(addr, lanes, wdata);
        end
        for (int i = 0; i < 32; i++) begin
            read_check($sformatf("work ram %h", slot_addr(i)), slot_addr(i));
        end

        // Input ports
        for (int r = 0; r < 4; r++) begin
            @(negedge clk);
            joystick_p1 = 8'($random(seed));
            joystick_p2 = 8'($random(seed));
            dswa = 8'($random(seed));
            dswb = 8'($random(seed));
            start = 2'($random(seed));
            coin = 2'($random(seed));
            for (int k = 0; k < 4; k++) begin
                read_check($sformatf("input word %0d", k), 24'h300000 + 24'(2 * k));
            end
        end

        // Interrupt levels
        @(negedge clk);
        vblank_n = 1'b0;
        repeat (2) @(negedge clk);
        check_value("ipl after vblank", 32'(ipl_for_level(5)), 32'(ipl_n));
        dma_n = 1'b0;
        @(negedge clk);
        dma_n = 1'b1;
        repeat (2) @(negedge clk);
        check_value("ipl after dma end", 32'(ipl_for_level(6)), 32'(ipl_n));
        int_ack(3'd6);
        check_value("ipl after ack 6", 32'(ipl_for_level(5)), 32'(ipl_n));
        int_ack(3'd5);
        check_value("ipl after ack 5", 32'(ipl_for_level(0)), 32'(ipl_n));
        vblank_n = 1'b1;

        // Save sequence
        @(negedge clk);
        ss_do_save = 1'b1;
        @(negedge clk);
        ss_do_save = 1'b0;
        @(negedge clk);
        check_value("ipl after save request", 32'(ipl_for_level(7)), 32'(ipl_n));
        int_ack(3'd7);
        check_value("ipl after ack 7", 32'(ipl_for_level(0)), 32'(ipl_n));
        read_check("save vector high", 24'h00007c);
        read_check("save vector low", 24'h00007e);
        ssp_value = 32'($random(seed));
        bus_write(24'hff0000, 3'b101, 2'b00, ssp_value[31:16]);
        bus_write(24'hff0002, 3'b101, 2'b00, ssp_value[15:0]);
        @(negedge clk);
        check_value("saved stack pointer", ssp_value, ss_saved_ssp);
        wait_until(W_PAUSE, "pause during save", 8);
        wait_until(W_WRITE, "ss_write", SETTLE + 8);
        ss_busy = 1'b1;
        repeat (3) @(negedge clk);
        check_value("ss_write after busy", 32'(1'b0), 32'(ss_write));
        ss_busy = 1'b0;
        wait_until(W_HANDLER, "handler wait state", 8);
        for (int i = 0; i < 13; i++) begin
            read_check($sformatf("handler word %0d", i), 24'hff0000 + 24'(2 * i));
        end
        bus_read(24'hff0000, 3'b110, data);
        @(negedge clk);
        check_value("state after save fetch", 32'(0), 32'(ss_state));
        check_value("pause after save", 32'(1'b0), 32'(pause));

        // Restore sequence
        @(negedge clk);
        ss_restore_ssp = 32'($random(seed));
        ss_do_restore = 1'b1;
        @(negedge clk);
        ss_do_restore = 1'b0;
        wait_until(W_RESET_ON, "cpu_reset on restore", 4);
        wait_until(W_READ, "ss_read", SETTLE + 8);
        ss_busy = 1'b1;
        repeat (3) @(negedge clk);
        check_value("ss_read after busy", 32'(1'b0), 32'(ss_read));
        ss_busy = 1'b0;
        wait_until(W_RESET_OFF, "cpu_reset release", HOLD + 10);
        for (int i = 0; i < 4; i++) begin
            read_check($sformatf("reset vector word %0d", i), 24'(2 * i));
        end
        bus_read(24'hff0000, 3'b110, data);
        @(negedge clk);
        check_value("state after restore fetch", 32'(0), 32'(ss_state));

        repeat (4) @(negedge clk);
        $display("Run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles with %0d errors", WATCHDOG_CYCLES,
                 errors);
        $display("Some tests failed");
        $finish;
    end

endmodule

//--- f2_cpu_glue.f
rtl/f2_glue_pkg.sv
rtl/cpu_bus_if.sv
rtl/address_decoder.sv
rtl/work_ram.sv
rtl/cpu_data_path.sv
rtl/interrupt_ctrl.sv
rtl/save_state_seq.sv
rtl/f2_cpu_glue.sv
testbench/f2_cpu_glue_sva.sv
testbench/tb_f2_cpu_glue.sv

//--- Makefile
SRCS := $(shell cat f2_cpu_glue.f)

.PHONY: run clean

obj_dir/Vtb_f2_cpu_glue: f2_cpu_glue.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_f2_cpu_glue \
		-f f2_cpu_glue.f

run: obj_dir/Vtb_f2_cpu_glue
	@out="$$(./obj_dir/Vtb_f2_cpu_glue)"; echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
